// ==== muldiv_pkg.sv ====
/* Width, value type, opcodes, FSM states and fixed latencies of the multiply-divide unit.
   Every RTL block and the testbench import what they need from here. */
package muldiv_pkg;

	// ======================================================================
	// Width and value type
	// ======================================================================

	// Operand and result width of the integer core
	localparam int xlen = 32;

	// Step counters in both units must hold xlen+1
	localparam int cnt_w = $clog2(xlen + 2);

	// Operands, partial results and final results all share this type
	typedef logic [xlen-1:0] value_t;

	// ======================================================================
	// Latencies
	// ======================================================================

	// Load strobe to done pulse of the multiplier
	// One input register cycle, xlen add-shift steps, one sign cycle, then done
	localparam int mul_cycles = xlen + 3;

	// Load strobe to done pulse of the divider
	// One input register cycle and xlen+1 compare/shift pairs
	// A last compare sees the count run out, then sign correction, then done
	localparam int div_cycles = 2 * xlen + 6;

	// ======================================================================
	// Opcodes and states
	// ======================================================================

	// Bit 2 set marks the divide group
	typedef enum logic [2:0] {
		op_mul    = 3'd0,
		op_mulh   = 3'd1,
		op_mulhsu = 3'd2,
		op_mulhu  = 3'd3,
		op_div    = 3'd4,
		op_divu   = 3'd5,
		op_rem    = 3'd6,
		op_remu   = 3'd7
	} muldiv_op_t;

	// Restoring divider with a compare state and a shift-subtract state per bit
	typedef enum logic [2:0] {
		div_idle  = 3'd0,
		div_cmp   = 3'd1,
		div_shift = 3'd2,
		div_sign  = 3'd3,
		div_done  = 3'd4
	} div_state_t;

	// Shift-add multiplier with one accumulate step per multiplier bit
	typedef enum logic [1:0] {
		mul_idle = 2'd0,
		mul_step = 2'd1,
		mul_sign = 2'd2,
		mul_done = 2'd3
	} mul_state_t;

endpackage

// ==== seq_divider.sv ====
/* Iterative restoring divider with truncating sign handling and a divide-by-zero flag.
   Pulse ld with the operands and sign mode, and quo and rem are valid while done is high. */
`timescale 1ns/1ps

module seq_divider (
	input  logic               clk,
	input  logic               rst,
	input  logic               ld,
	input  logic               sgn,
	input  logic               sgnus,
	input  muldiv_pkg::value_t a,
	input  muldiv_pkg::value_t b,
	output muldiv_pkg::value_t quo,
	output muldiv_pkg::value_t rem,
	output logic               dvbyzr,
	output logic               done
);
	import muldiv_pkg::*;

	div_state_t state;
	logic [cnt_w-1:0] cnt;

	// Input register stage
	logic ld1;
	logic sgn1;
	logic sgnus1;
	value_t a1;
	value_t b1;

	// Divisor magnitude, quotient shift register and partial remainder
	value_t bb;
	value_t q;
	logic [xlen:0] r;
	value_t r1;
	logic b0;

	// Result signs for quotient and remainder
	logic qs;
	logic rs;

	// Subtract only when the last compare found the divisor fits
	// The difference is always below bb so it fits in xlen bits
	assign r1 = b0 ? value_t'(r - {1'b0, bb}) : r[xlen-1:0];

	assign done = (state == div_done);

	// ======================================================================
	// Input register
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst)
			ld1 <= 1'b0;
		else
			ld1 <= ld;
	end

	always_ff @(posedge clk) begin
		a1 <= a;
		b1 <= b;
		sgn1 <= sgn;
		sgnus1 <= sgnus;
	end

	// ======================================================================
	// Sequencer
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= div_idle;
			cnt <= '0;
			dvbyzr <= 1'b0;
		end else begin
			case (state)
				// The compare after the last shift only hands over to sign correction
				div_cmp:
					if (cnt == '0)
						state <= div_sign;
					else
						state <= div_shift;
				div_shift: begin
					cnt <= cnt - 1'b1;
					state <= div_cmp;
				end
				div_sign:
					state <= div_done;
				default:
					state <= div_idle;
			endcase
			// A new load restarts the divider from any state
			if (ld1) begin
				// One bit per pair plus one extra pair that shifts in the first dividend bit
				cnt <= cnt_w'((div_cycles - 6) / 2 + 1);
				dvbyzr <= (b1 == '0);
				state <= div_cmp;
			end
		end
	end

	// ======================================================================
	// Datapath
	// ======================================================================

	always_ff @(posedge clk) begin
		case (state)
			div_cmp:
				b0 <= ({1'b0, bb} <= r);
			div_shift: begin
				// Quotient bit enters at the bottom and the dividend MSB moves into r
				q <= {q[xlen-2:0], b0};
				r <= {r1, q[xlen-1]};
			end
			div_sign: begin
				quo <= qs ? -q : q;
				rem <= rs ? -r[xlen:1] : r[xlen:1];
			end
			default: ;
		endcase
		if (ld1) begin
			// Zero divisor keeps a positive all-ones quotient in every mode
			if (sgn1) begin
				q <= a1[xlen-1] ? -a1 : a1;
				bb <= b1[xlen-1] ? -b1 : b1;
				qs <= (a1[xlen-1] ^ b1[xlen-1]) & (|b1);
				rs <= a1[xlen-1];
			end else if (sgnus1) begin
				q <= a1[xlen-1] ? -a1 : a1;
				bb <= b1;
				qs <= a1[xlen-1] & (|b1);
				rs <= a1[xlen-1];
			end else begin
				q <= a1;
				bb <= b1;
				qs <= 1'b0;
				rs <= 1'b0;
			end
			r <= '0;
		end
	end

endmodule

// ==== seq_multiplier.sv ====
/* Iterative shift-add multiplier working on operand magnitudes, giving a 64-bit product.
   Pulse ld with the operands and sign mode, and prod_hi and prod_lo are valid at done. */
`timescale 1ns/1ps

module seq_multiplier (
	input  logic               clk,
	input  logic               rst,
	input  logic               ld,
	input  logic               sgn,
	input  logic               sgnus,
	input  muldiv_pkg::value_t a,
	input  muldiv_pkg::value_t b,
	output muldiv_pkg::value_t prod_lo,
	output muldiv_pkg::value_t prod_hi,
	output logic               done
);
	import muldiv_pkg::*;

	mul_state_t state;
	logic [cnt_w-1:0] cnt;

	// Input register stage
	logic ld1;
	logic sgn1;
	logic sgnus1;
	value_t a1;
	value_t b1;

	// Multiplicand magnitude and the double-width accumulator
	// The multiplier magnitude starts in the low half and is shifted out bit by bit
	value_t mcand;
	logic [2*xlen-1:0] acc;
	logic [xlen:0] sum;

	// Product sign
	logic ps;

	// Upper half plus the multiplicand when the current multiplier bit is set
	assign sum = {1'b0, acc[2*xlen-1:xlen]} + (acc[0] ? {1'b0, mcand} : '0);

	assign done = (state == mul_done);

	// ======================================================================
	// Input register and sequencer
	// ======================================================================

	always_ff @(posedge clk) begin
		a1 <= a;
		b1 <= b;
		sgn1 <= sgn;
		sgnus1 <= sgnus;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ld1 <= 1'b0;
			state <= mul_idle;
			cnt <= '0;
		end else begin
			ld1 <= ld;
			case (state)
				mul_step: begin
					cnt <= cnt - 1'b1;
					if (cnt == cnt_w'(1))
						state <= mul_sign;
				end
				mul_sign:
					state <= mul_done;
				default:
					state <= mul_idle;
			endcase
			if (ld1) begin
				// Everything except the input, sign and done cycles is stepping
				cnt <= cnt_w'(mul_cycles - 3);
				state <= mul_step;
			end
		end
	end

	// ======================================================================
	// Datapath
	// ======================================================================

	always_ff @(posedge clk) begin
		case (state)
			mul_step:
				acc <= {sum, acc[xlen-1:1]};
			mul_sign:
				{prod_hi, prod_lo} <= ps ? -acc : acc;
			default: ;
		endcase
		if (ld1) begin
			// In signed-by-unsigned mode only a carries a sign
			if (sgn1) begin
				mcand <= a1[xlen-1] ? -a1 : a1;
				acc <= {{xlen{1'b0}}, (b1[xlen-1] ? -b1 : b1)};
				ps <= a1[xlen-1] ^ b1[xlen-1];
			end else if (sgnus1) begin
				mcand <= a1[xlen-1] ? -a1 : a1;
				acc <= {{xlen{1'b0}}, b1};
				ps <= a1[xlen-1];
			end else begin
				mcand <= a1;
				acc <= {{xlen{1'b0}}, b1};
				ps <= 1'b0;
			end
		end
	end

endmodule

// ==== muldiv_control.sv ====
/* Opcode decode, unit start, busy tracking and result selection for the multiply-divide unit.
   Accepts ld only while idle and holds res and dbz from one done pulse to the next. */
`timescale 1ns/1ps

module muldiv_control (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ld,
	input  muldiv_pkg::muldiv_op_t op,
	input  muldiv_pkg::value_t     a,
	input  muldiv_pkg::value_t     b,
	input  logic                   mul_done,
	input  logic                   div_done,
	input  muldiv_pkg::value_t     prod_lo,
	input  muldiv_pkg::value_t     prod_hi,
	input  muldiv_pkg::value_t     quo,
	input  muldiv_pkg::value_t     rem,
	input  logic                   dvbyzr,
	output logic                   mul_ld,
	output logic                   div_ld,
	output logic                   sgn,
	output logic                   sgnus,
	output muldiv_pkg::value_t     opa,
	output muldiv_pkg::value_t     opb,
	output muldiv_pkg::value_t     res,
	output logic                   dbz,
	output logic                   done,
	output logic                   busy
);
	import muldiv_pkg::*;

	muldiv_op_t op_q;
	logic accept;
	logic unit_done;
	value_t sel;

	function automatic logic is_div_op(input muldiv_op_t o);
		return o inside {op_div, op_divu, op_rem, op_remu};
	endfunction

	// A strobe that arrives while busy is simply dropped
	assign accept = ld & ~busy;

	// Only the unit that was started can answer
	assign unit_done = busy & (is_div_op(op_q) ? div_done : mul_done);

	// Pick the product half, quotient or remainder by the held opcode
	always_comb begin
		case (op_q)
			op_mul:                       sel = prod_lo;
			op_mulh, op_mulhsu, op_mulhu: sel = prod_hi;
			op_div, op_divu:              sel = quo;
			default:                      sel = rem;
		endcase
	end

	// ======================================================================
	// Issue, busy and result registers
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			op_q <= op_mul;
			sgn <= 1'b0;
			sgnus <= 1'b0;
			mul_ld <= 1'b0;
			div_ld <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			res <= '0;
			dbz <= 1'b0;
		end else begin
			// Unit strobes come one cycle after the accepted ld
			mul_ld <= accept & ~is_div_op(op);
			div_ld <= accept & is_div_op(op);
			done <= unit_done;
			if (accept) begin
				op_q <= op;
				busy <= 1'b1;
				sgn <= op inside {op_mul, op_mulh, op_div, op_rem};
				sgnus <= (op == op_mulhsu);
			end else if (done) begin
				busy <= 1'b0;
			end
			if (unit_done) begin
				res <= sel;
				dbz <= is_div_op(op_q) & dvbyzr;
			end
		end
	end

	// Operands only need to be stable when the unit samples them
	always_ff @(posedge clk) begin
		if (accept) begin
			opa <= a;
			opb <= b;
		end
	end

endmodule

// ==== muldiv_unit.sv ====
/* Top level of the multiply-divide unit with the control block and both arithmetic units.
   Drive ld with op, a and b while busy is low, and read res and dbz when done pulses. */
`timescale 1ns/1ps

module muldiv_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ld,
	input  muldiv_pkg::muldiv_op_t op,
	input  muldiv_pkg::value_t     a,
	input  muldiv_pkg::value_t     b,
	output muldiv_pkg::value_t     res,
	output logic                   dbz,
	output logic                   done,
	output logic                   busy
);
	import muldiv_pkg::*;

	// Start strobes and the shared sign mode and operands
	logic mul_ld;
	logic div_ld;
	logic sgn;
	logic sgnus;
	value_t opa;
	value_t opb;

	// Answers from the two units
	logic mul_done;
	logic div_done;
	value_t prod_lo;
	value_t prod_hi;
	value_t quo;
	value_t rem;
	logic dvbyzr;

	muldiv_control i_muldiv_control (
		.clk      (clk),
		.rst      (rst),
		.ld       (ld),
		.op       (op),
		.a        (a),
		.b        (b),
		.mul_done (mul_done),
		.div_done (div_done),
		.prod_lo  (prod_lo),
		.prod_hi  (prod_hi),
		.quo      (quo),
		.rem      (rem),
		.dvbyzr   (dvbyzr),
		.mul_ld   (mul_ld),
		.div_ld   (div_ld),
		.sgn      (sgn),
		.sgnus    (sgnus),
		.opa      (opa),
		.opb      (opb),
		.res      (res),
		.dbz      (dbz),
		.done     (done),
		.busy     (busy)
	);

	seq_multiplier i_seq_multiplier (
		.clk     (clk),
		.rst     (rst),
		.ld      (mul_ld),
		.sgn     (sgn),
		.sgnus   (sgnus),
		.a       (opa),
		.b       (opb),
		.prod_lo (prod_lo),
		.prod_hi (prod_hi),
		.done    (mul_done)
	);

	seq_divider i_seq_divider (
		.clk    (clk),
		.rst    (rst),
		.ld     (div_ld),
		.sgn    (sgn),
		.sgnus  (sgnus),
		.a      (opa),
		.b      (opb),
		.quo    (quo),
		.rem    (rem),
		.dvbyzr (dvbyzr),
		.done   (div_done)
	);

endmodule

// ==== muldiv_sva.sv ====
/* Handshake properties of the multiply-divide control block.
   Attached to every muldiv_control instance by the bind at the end of this file. */
`timescale 1ns/1ps

module muldiv_sva (
	input logic clk,
	input logic rst,
	input logic ld,
	input logic mul_ld,
	input logic div_ld,
	input logic done,
	input logic busy
);

	// Number of property failures, summed up by the testbench at the end of the run
	int err_count = 0;

	// One operation starts one arithmetic unit, never both
	one_unit_started: assert property (@(posedge clk) disable iff (rst)
		!(mul_ld && div_ld))
	else begin
		err_count++;
		$error("mul_ld and div_ld are high in the same cycle");
	end

	// The top done is a single-cycle pulse
	done_single_pulse: assert property (@(posedge clk) disable iff (rst)
		done |=> !done)
	else begin
		err_count++;
		$error("done stayed high for more than one cycle");
	end

	// The unit is free again right after it reports done
	done_then_idle: assert property (@(posedge clk) disable iff (rst)
		done |=> !busy)
	else begin
		err_count++;
		$error("busy still high in the cycle after done");
	end

	// busy only rises on a strobe sampled at the previous edge
	busy_needs_ld: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> $past(ld))
	else begin
		err_count++;
		$error("busy rose without a load strobe");
	end

endmodule

bind muldiv_control muldiv_sva i_muldiv_sva (
	.clk    (clk),
	.rst    (rst),
	.ld     (ld),
	.mul_ld (mul_ld),
	.div_ld (div_ld),
	.done   (done),
	.busy   (busy)
);

// ==== tb_clock.sv ====
/* Free-running clock for the multiply-divide testbench, 8 ns period.
   Instantiate once in the testbench top and use its clk output. */
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// Low for the first half period so the first rising edge lands at 4 ns
	initial begin
		clk = 1'b0;
	end

	// Half of the 8 ns period
	always begin
		#4 clk = ~clk;
	end

endmodule

// ==== muldiv_tb.sv ====
/* Self-checking testbench for the multiply-divide unit with a reference model and a watchdog.
   Runs reset, product, quotient, divide-by-zero and busy-rejection tests, then a summary. */
`timescale 1ns/1ps

module muldiv_tb;
	import muldiv_pkg::*;

	// ======================================================================
	// Run length
	// ======================================================================

	localparam int reset_cycles = 16;
	// Random operand pairs per opcode in the product and quotient tests
	localparam int rand_n = 8;
	// Products, quotients plus two overflow cases, divide by zero, busy rejection
	// The last two are the divide and the interrupted divide around the second reset
	localparam int num_ops = 4 * (16 + rand_n) + 4 * rand_n + 2 + 5 + 2 + 2;
	// Two resets and a generous bound for every operation
	localparam int run_cycles = 2 * reset_cycles + num_ops * (div_cycles + 10);

	logic clk;
	logic rst;
	logic ld;
	muldiv_op_t op;
	value_t a;
	value_t b;
	value_t res;
	logic dbz;
	logic done;
	logic busy;

	int pass_cnt = 0;
	int fail_cnt = 0;
	int op_cnt = 0;

	// Result the DUT must keep showing until its next done pulse
	value_t last_res = '0;
	logic last_dbz = 1'b0;

	muldiv_op_t mul_ops[4] = '{op_mul, op_mulh, op_mulhsu, op_mulhu};
	muldiv_op_t div_ops[4] = '{op_div, op_divu, op_rem, op_remu};
	value_t corners[4] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};

	tb_clock i_tb_clock (
		.clk (clk)
	);

	muldiv_unit i_muldiv_unit (
		.clk  (clk),
		.rst  (rst),
		.ld   (ld),
		.op   (op),
		.a    (a),
		.b    (b),
		.res  (res),
		.dbz  (dbz),
		.done (done),
		.busy (busy)
	);

	// ======================================================================
	// Reference model and checking helpers
	// ======================================================================

	// Exact 64-bit arithmetic, truncating division, dividend-signed remainder
	// Division by zero gives an all-ones quotient and the dividend as remainder
	function automatic value_t model_result(input muldiv_op_t o, input value_t x,
			input value_t y);
		longint sx;
		longint sy;
		longint ux;
		longint uy;
		longint p;
		sx = longint'($signed(x));
		sy = longint'($signed(y));
		ux = longint'(x);
		uy = longint'(y);
		case (o)
			op_mul:    p = sx * sy;
			op_mulh:   p = (sx * sy) >> xlen;
			op_mulhsu: p = (sx * uy) >> xlen;
			op_mulhu:  p = (ux * uy) >> xlen;
			op_div:
				if (y == '0)
					p = -1;
				else
					p = sx / sy;
			op_divu:
				if (y == '0)
					p = -1;
				else
					p = ux / uy;
			op_rem:
				if (y == '0)
					p = sx;
				else
					p = sx % sy;
			default:
				if (y == '0)
					p = ux;
				else
					p = ux % uy;
		endcase
		return value_t'(p);
	endfunction

	task automatic check_that(input bit ok, input string msg);
		assert (ok) begin
			pass_cnt++;
		end else begin
			fail_cnt++;
			$display("Fail at %0t: %s", $time, msg);
		end
	endtask

	task automatic end_test(input string name, input int ops_at_start,
			input int fails_at_start);
		$display("[%s] %0d operations, %0d failing checks", name, op_cnt - ops_at_start,
			fail_cnt - fails_at_start);
	endtask

	// Holds rst for the reset length, then the outputs must come back cleared
	task automatic apply_reset(input string when);
		rst = 1'b1;
		ld = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;
		last_res = '0;
		last_dbz = 1'b0;
		check_that(!done && !busy && !dbz && res == '0,
			$sformatf("%s done=%b busy=%b dbz=%b res=%h", when, done, busy, dbz, res));
	endtask

	// Issues one operation and follows it to one cycle past its done pulse
	// With intrude set a second ld with other operands arrives while busy
	task automatic run_op(input muldiv_op_t o, input value_t x, input value_t y,
			input bit intrude);
		value_t exp_res;
		logic exp_dbz;
		bit is_div;
		int lat;
		int cyc;
		is_div = o inside {op_div, op_divu, op_rem, op_remu};
		exp_res = model_result(o, x, y);
		exp_dbz = is_div && (y == '0);
		lat = is_div ? div_cycles + 2 : mul_cycles + 2;
		op_cnt++;
		@(negedge clk);
		op = o;
		a = x;
		b = y;
		ld = 1'b1;
		cyc = 0;
		while (!done && cyc <= lat + 4) begin
			@(negedge clk);
			cyc++;
			if (!done) begin
				check_that(busy, $sformatf("%s busy low %0d cycles after ld", o.name(), cyc));
				check_that(res == last_res && dbz == last_dbz,
					$sformatf("%s res or dbz changed before done", o.name()));
			end
			ld = intrude && (cyc == 4);
			if (ld) begin
				op = op_remu;
				a = ~x;
				b = 32'd3;
			end
		end
		check_that(done, $sformatf("%s gave no done within %0d cycles", o.name(), lat + 4));
		check_that(cyc == lat,
			$sformatf("%s done after %0d cycles, expected %0d", o.name(), cyc, lat));
		check_that(busy, $sformatf("%s busy low while done is high", o.name()));
		check_that(res == exp_res, $sformatf("%s a=%h b=%h res=%h expected %h",
			o.name(), x, y, res, exp_res));
		check_that(dbz == exp_dbz, $sformatf("%s a=%h b=%h dbz=%b expected %b",
			o.name(), x, y, dbz, exp_dbz));
		last_res = exp_res;
		last_dbz = exp_dbz;
		@(negedge clk);
		check_that(!done && !busy,
			$sformatf("%s done=%b busy=%b one cycle after done", o.name(), done, busy));
		check_that(res == last_res, $sformatf("%s res not held after done", o.name()));
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		int seed;
		int sva_fails;
		int fails_at_start;
		int ops_at_start;
		value_t x;
		value_t y;
		rst = 1'b1;
		ld = 1'b0;
		op = op_mul;
		a = '0;
		b = '0;
		seed = $urandom(88);

		// Outputs straight out of the first reset
		fails_at_start = fail_cnt;
		ops_at_start = op_cnt;
		apply_reset("after reset");
		end_test("reset", ops_at_start, fails_at_start);

		// Every corner pair, then random pairs, for each product opcode
		fails_at_start = fail_cnt;
		ops_at_start = op_cnt;
		foreach (mul_ops[i]) begin
			foreach (corners[j]) begin
				foreach (corners[k]) begin
					run_op(mul_ops[i], corners[j], corners[k], 1'b0);
				end
			end
			for (int n = 0; n < rand_n; n++) begin
				run_op(mul_ops[i], $urandom, $urandom, 1'b0);
			end
		end
		end_test("products", ops_at_start, fails_at_start);

		// Mix of wide and small divisors, some of them negated
		fails_at_start = fail_cnt;
		ops_at_start = op_cnt;
		foreach (div_ops[i]) begin
			for (int n = 0; n < rand_n; n++) begin
				x = $urandom;
				if (n % 2 == 0)
					y = $urandom;
				else
					y = value_t'($urandom_range(255, 1));
				if (n % 4 == 3)
					y = -y;
				if (y == '0)
					y = 32'd7;
				run_op(div_ops[i], x, y, 1'b0);
			end
		end
		// The one signed quotient that does not fit
		run_op(op_div, 32'h8000_0000, 32'hffff_ffff, 1'b0);
		run_op(op_rem, 32'h8000_0000, 32'hffff_ffff, 1'b0);
		end_test("quotients", ops_at_start, fails_at_start);

		// A zero divisor for each divide opcode, then a product must clear dbz
		fails_at_start = fail_cnt;
		ops_at_start = op_cnt;
		foreach (div_ops[i]) begin
			run_op(div_ops[i], $urandom, '0, 1'b0);
		end
		run_op(op_mul, 32'd6, 32'd7, 1'b0);
		end_test("divide_by_zero", ops_at_start, fails_at_start);

		fails_at_start = fail_cnt;
		ops_at_start = op_cnt;
		run_op(op_mulh, $urandom, $urandom, 1'b1);
		run_op(op_div, $urandom, 32'd13, 1'b1);
		end_test("busy_rejection", ops_at_start, fails_at_start);

		// Reset while a division runs, with dbz and res still set by a zero divisor
		fails_at_start = fail_cnt;
		ops_at_start = op_cnt;
		run_op(op_divu, 32'h1234_5678, '0, 1'b0);
		op_cnt++;
		@(negedge clk);
		op = op_div;
		a = 32'h8765_4321;
		b = 32'd5;
		ld = 1'b1;
		@(negedge clk);
		check_that(busy, "busy low after the load issued ahead of the reset");
		apply_reset("after reset during a division");
		end_test("reset_while_busy", ops_at_start, fails_at_start);

		sva_fails = i_muldiv_unit.i_muldiv_control.i_muldiv_sva.err_count;
		$display("Summary: %0d checks passed, %0d checks failed, %0d assertion failures",
			pass_cnt, fail_cnt, sva_fails);
		if (fail_cnt == 0 && sva_fails == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// ======================================================================
	// Watchdog
	// ======================================================================

	// Every operation finishes well inside div_cycles+10 cycles
	initial begin
		repeat (run_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", run_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== list.f ====
muldiv_pkg.sv
seq_divider.sv
seq_multiplier.sv
muldiv_control.sv
muldiv_unit.sv
muldiv_sva.sv
tb_clock.sv
muldiv_tb.sv

// ==== Makefile ====
# Verilator build and run of the multiply-divide unit testbench

LOG = sim.log

all: run

build:
	verilator --binary --assert -Wno-fatal -j 0 --top-module muldiv_tb -f list.f -o muldiv_sim

# The run passes only if the log holds the pass message
run: build
	./obj_dir/muldiv_sim +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG)

lint:
	verilator --lint-only --timing -Wall --top-module muldiv_tb -f list.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
